// ==== asym_fifo_pkg.sv ====
package asym_fifo_pkg;

	// Geometry of the narrow-in, wide-out path
	localparam int IN_W   = 8;              // Subword width
	localparam int OUT_W  = 32;             // Word width
	localparam int RATIO  = OUT_W / IN_W;   // Subwords per word
	localparam int CNT_W  = $clog2(RATIO);  // Subword counter width
	localparam int DEPTH  = 8;              // RAM words
	localparam int ADDR_W = $clog2(DEPTH);
	localparam int PTR_W  = ADDR_W + 1;     // Extra wrap bit
	localparam int AF_LVL = 2;              // Free words at or below this raise af
	localparam int AE_LVL = 2;              // Stored words at or below this raise ae

	typedef logic [IN_W-1:0]   in_word_t;
	typedef logic [OUT_W-1:0]  out_word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [PTR_W-1:0]  ptr_t;       // Binary or Gray, by context
	typedef logic [CNT_W-1:0]  cnt_t;

	// Compare levels sized to the counters
	localparam cnt_t LAST_CNT = cnt_t'(RATIO - 1);
	localparam ptr_t FULL_LVL = ptr_t'(DEPTH);
	localparam ptr_t AF_FILL  = ptr_t'(DEPTH - AF_LVL);  // Fill where af starts
	localparam ptr_t AE_FILL  = ptr_t'(AE_LVL);

	// --------------------
	// Flag and bus bundles
	typedef struct packed {
		logic full;      // Input buffer counted too
		logic ram_full;
		logic af;
		logic part_wd;
		logic error;     // Sticky overrun
	} push_flags_t;

	typedef struct packed {
		logic empty;
		logic ae;
		logic error;     // Sticky underrun
	} pop_flags_t;

	typedef struct packed {
		logic      we;
		addr_t     addr;
		out_word_t data;
	} wr_req_t;

	// --------------------
	// Gray code helpers for the pointer crossings
	function automatic ptr_t bin2gray(input ptr_t b);
		return b ^ (b >> 1);
	endfunction

	function automatic ptr_t gray2bin(input ptr_t g);
		ptr_t b;
		b[PTR_W-1] = g[PTR_W-1];
		for (int i = PTR_W - 2; i >= 0; i--)
			b[i] = b[i+1] ^ g[i];   // Running XOR from the MSB down
		return b;
	endfunction

endpackage

// ==== asym_fifo_props.sv ====
`timescale 1ns/1ps

module asym_fifo_props (
	input logic                       clk_push,
	input logic                       clk_pop,
	input logic                       rst_n,
	input asym_fifo_pkg::wr_req_t     wr_req,
	input asym_fifo_pkg::push_flags_t push_flags,
	input asym_fifo_pkg::pop_flags_t  pop_flags
);

	// --------------------
	// Push domain
	// A write into a full RAM would land on the head word
	a_no_write_full: assert property (@(posedge clk_push) disable iff (!rst_n)
		!(wr_req.we && push_flags.ram_full)) else $error("RAM write while ram_full is set");

	a_push_after_reset: assert property (@(posedge clk_push)
		$rose(rst_n) |-> !push_flags.part_wd && !push_flags.error)
		else $error("part_wd or push error set coming out of reset");

	// Full needs held subwords, never an empty input buffer
	a_full_view: assert property (@(posedge clk_push) disable iff (!rst_n)
		push_flags.full |-> push_flags.part_wd)
		else $error("full raised while the input buffer is empty");

	// --------------------
	// Pop domain
	a_pop_after_reset: assert property (@(posedge clk_pop)
		$rose(rst_n) |-> !pop_flags.error) else $error("pop error set coming out of reset");

endmodule

bind asym_fifo_top asym_fifo_props u_props (
	.clk_push (clk_push), .clk_pop (clk_pop), .rst_n (rst_n),
	.wr_req (wr_req), .push_flags (push_flags), .pop_flags (pop_flags)
);

// ==== asym_fifo_tb.sv ====
`timescale 1ns/1ps

module asym_fifo_tb;

	logic clk_push, clk_pop, rst_n;
	logic push_req_n, flush_n, pop_req_n;
	asym_fifo_pkg::in_word_t    data_in;
	asym_fifo_pkg::out_word_t   data_out;
	asym_fifo_pkg::push_flags_t push_flags;
	asym_fifo_pkg::pop_flags_t  pop_flags;

	asym_fifo_pkg::out_word_t   model_q[$];   // Words written and not yet popped
	asym_fifo_pkg::out_word_t   part_word;    // Held subwords, first one at the MSB
	int   part_cnt, errors, errs_seen, tests_run, tests_failed;
	logic push_err_exp, pop_err_exp;          // Sticky errors the model expects

	tb_clocks u_clocks (.clk_push(clk_push), .clk_pop(clk_pop), .rst_n(rst_n));

	asym_fifo_top DUT (
		.clk_push (clk_push), .clk_pop (clk_pop), .rst_n (rst_n),
		.push_req_n (push_req_n), .flush_n (flush_n), .data_in (data_in),
		.push_flags (push_flags), .pop_req_n (pop_req_n),
		.data_out (data_out), .pop_flags (pop_flags)
	);

	// --------------------
	// Compare tasks
	task automatic check_word(input asym_fifo_pkg::out_word_t got, exp);
		if (got !== exp)
		begin
			errors++;
			$display("Error at %t: data_out is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_push_flags(input asym_fifo_pkg::push_flags_t got, exp, mask);
		if ((got & mask) !== (exp & mask))
		begin
			errors++;
			$display("Error at %t: push_flags is %b, expected %b", $time, got & mask, exp & mask);
		end
	endtask

	task automatic check_pop_flags(input asym_fifo_pkg::pop_flags_t got, exp);
		if (got !== exp)
		begin
			errors++;
			$display("Error at %t: pop_flags is %b, expected %b", $time, got, exp);
		end
	endtask

	// --------------------
	// One push clock, checked, driven on the falling edge, then the model steps
	task automatic push_cycle(input logic req, input logic flush, input logic gate);
		asym_fifo_pkg::push_flags_t want;
		asym_fifo_pkg::in_word_t    d;
		logic                       ram_full_m;
		d = asym_fifo_pkg::in_word_t'($urandom);
		@(negedge clk_push);
		want         = '0;
		want.part_wd = (part_cnt != 0);
		want.error   = push_err_exp;
		check_push_flags(push_flags, want, 5'b00011);   // part_wd and error only
		if (gate && push_flags.ram_full)
		begin
			req   = 1'b0;                  // Hold off until a pop frees a word
			flush = 1'b0;
		end
		push_req_n = ~req;
		flush_n    = ~flush;
		data_in    = d;
		ram_full_m = (model_q.size() == asym_fifo_pkg::DEPTH);
		if (req && ram_full_m && part_cnt == asym_fifo_pkg::RATIO - 1)
			push_err_exp = 1'b1;           // Dropped subword
		else if (req)
		begin
			part_word |= asym_fifo_pkg::out_word_t'(d)
				<< (asym_fifo_pkg::IN_W * (asym_fifo_pkg::RATIO - 1 - part_cnt));
			part_cnt++;
		end
		// Fourth subword or a flush with something held, zero fill already in place
		if (part_cnt == asym_fifo_pkg::RATIO || (flush && part_cnt != 0 && !ram_full_m))
		begin
			model_q.push_back(part_word);
			part_word = '0;
			part_cnt  = 0;
		end
	endtask

	// One pop clock, a pop only goes out while the DUT shows data
	task automatic pop_cycle(input logic want);
		@(negedge clk_pop);
		pop_req_n = 1'b1;
		if (want && !pop_flags.empty)
		begin
			if (model_q.size() == 0)
			begin
				errors++;
				$display("FIFO shows a word at %t that was never written", $time);
			end
			else
			begin
				check_word(data_out, model_q.pop_front());   // Head shows before the pop
				pop_req_n = 1'b0;
			end
		end
	endtask

	task automatic drain();
		int tries;
		tries = 0;
		while (model_q.size() != 0 && tries < 200)
		begin
			pop_cycle(1'b1);
			tries++;
		end
		pop_cycle(1'b0);
		if (model_q.size() != 0)
		begin
			errors++;
			$display("Timeout: %0d words never reached the pop side", model_q.size());
		end
	endtask

	// Flags against the model count once both synchronizers have caught up
	task automatic check_settled();
		asym_fifo_pkg::push_flags_t pf;
		asym_fifo_pkg::pop_flags_t  qf;
		int n;
		repeat (4) @(negedge clk_pop);  // 2 to 3 cycles of either clock
		n           = model_q.size();
		pf.ram_full = (n == asym_fifo_pkg::DEPTH);
		pf.af       = (asym_fifo_pkg::DEPTH - n <= asym_fifo_pkg::AF_LVL);
		pf.part_wd  = (part_cnt != 0);
		pf.full     = pf.ram_full && part_cnt == asym_fifo_pkg::RATIO - 1;
		pf.error    = push_err_exp;
		qf.empty    = (n == 0);
		qf.ae       = (n <= asym_fifo_pkg::AE_LVL);
		qf.error    = pop_err_exp;
		check_pop_flags(pop_flags, qf);
		@(negedge clk_push);
		check_push_flags(push_flags, pf, '1);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != errs_seen)
			tests_failed++;
		$display("Test %0d %s: %s", tests_run, name, (errors == errs_seen) ? "ok" : "failed");
		errs_seen = errors;
	endtask

	// --------------------
	// Test sequence
	initial
	begin
		void'($urandom(2611));
		$timeformat(-9, 0, " ns", 0);
		push_req_n   = 1'b1;
		flush_n      = 1'b1;
		pop_req_n    = 1'b1;
		data_in      = '0;
		part_word    = '0;
		part_cnt     = 0;
		push_err_exp = 1'b0;
		pop_err_exp  = 1'b0;
		errors       = 0;
		errs_seen    = 0;
		tests_run    = 0;
		tests_failed = 0;
		for (int i = 0; i < 64 && rst_n !== 1'b1; i++)
			@(negedge clk_push);
		if (rst_n !== 1'b1)
		begin
			errors++;
			$display("Timeout: reset was never released");
		end
		else
		begin
			check_settled();
			end_test("reset values");
			for (int s = 0; s < 6 * asym_fifo_pkg::RATIO; s++)
				push_cycle(1'b1, 1'b0, 1'b0);
			push_cycle(1'b0, 1'b0, 1'b0);
			drain();
			check_settled();
			end_test("full words");
			// One to three subwords, the flush alone or with the last one
			for (int k = 1; k < asym_fifo_pkg::RATIO; k++)
				for (int mode = 0; mode < 2; mode++)
				begin
					for (int s = 0; s < k - mode; s++)
						push_cycle(1'b1, 1'b0, 1'b0);
					push_cycle(mode == 1, 1'b1, 1'b0);
				end
			push_cycle(1'b0, 1'b0, 1'b0);
			drain();
			check_settled();
			end_test("flush");
			for (int s = 0; s < (asym_fifo_pkg::DEPTH + 1) * asym_fifo_pkg::RATIO - 1; s++)
				push_cycle(1'b1, 1'b0, 1'b0);
			push_cycle(1'b0, 1'b1, 1'b0);    // Flush into a full RAM keeps the buffer
			push_cycle(1'b0, 1'b0, 1'b0);
			check_settled();
			push_cycle(1'b1, 1'b0, 1'b0);    // Dropped
			push_cycle(1'b0, 1'b0, 1'b0);
			check_settled();
			drain();
			check_settled();
			push_cycle(1'b0, 1'b1, 1'b0);    // Three held subwords go out
			push_cycle(1'b0, 1'b0, 1'b0);
			drain();
			check_settled();
			end_test("overrun");
			@(negedge clk_pop);
			pop_req_n   = 1'b0;              // FIFO is empty here
			pop_err_exp = 1'b1;
			pop_cycle(1'b0);
			for (int s = 0; s < asym_fifo_pkg::RATIO; s++)
				push_cycle(1'b1, 1'b0, 1'b0);
			push_cycle(1'b0, 1'b0, 1'b0);
			drain();
			check_settled();
			end_test("underrun");
			// Bursts alternate slow and fast pops so the fill level sweeps
			for (int b = 0; b < 6; b++)
			begin
				fork
					begin
						for (int c = 0; c < 60; c++)
							push_cycle(($urandom % 4) != 0, ($urandom % 8) == 0, 1'b1);
						push_cycle(1'b0, 1'b0, 1'b0);   // Request drops on the next edge
					end
					begin
						for (int c = 0; c < 40; c++)
							pop_cycle(int'($urandom % 4) < ((b % 2 == 1) ? 1 : 3));
						pop_cycle(1'b0);
					end
				join
				check_settled();
			end
			drain();
			check_settled();
			end_test("random traffic");
		end
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== asym_fifo_top.sv ====
`timescale 1ns/1ps

module asym_fifo_top (
	input  logic                       clk_push,
	input  logic                       clk_pop,
	input  logic                       rst_n,      // Both domains, async
	// Push side
	input  logic                       push_req_n,
	input  logic                       flush_n,
	input  asym_fifo_pkg::in_word_t    data_in,
	output asym_fifo_pkg::push_flags_t push_flags,
	// Pop side
	input  logic                       pop_req_n,
	output asym_fifo_pkg::out_word_t   data_out,   // Valid while not empty
	output asym_fifo_pkg::pop_flags_t  pop_flags
);

	asym_fifo_pkg::cnt_t      count;
	asym_fifo_pkg::out_word_t wr_data;
	asym_fifo_pkg::addr_t     wr_addr, rd_addr;
	asym_fifo_pkg::ptr_t      wr_gray, rd_gray;   // Cross the clock domains
	asym_fifo_pkg::wr_req_t   wr_req;
	logic last, accept, write, advance, clear;
	logic part_wd, push_err, ram_full, af;

	// --------------------
	// Push domain
	subword_counter u_cnt (
		.clk_push (clk_push), .rst_n (rst_n),
		.advance  (advance),  .clear (clear),
		.count    (count),    .last  (last)
	);

	pack_ctl_fsm u_ctl (
		.clk_push   (clk_push),   .rst_n    (rst_n),
		.push_req_n (push_req_n), .flush_n  (flush_n),
		.ram_full   (ram_full),   .last     (last),
		.accept     (accept),     .write    (write),
		.advance    (advance),    .clear    (clear),
		.part_wd    (part_wd),    .error    (push_err)
	);

	word_packer u_pack (
		.clk_push (clk_push), .rst_n  (rst_n),
		.data_in  (data_in),  .count  (count),
		.accept   (accept),   .write  (write),
		.wr_data  (wr_data)
	);

	push_ptr_flags u_wptr (
		.clk_push (clk_push), .rst_n    (rst_n),
		.write    (write),    .rd_gray  (rd_gray),
		.wr_gray  (wr_gray),  .wr_addr  (wr_addr),
		.ram_full (ram_full), .af       (af)
	);

	// Packer data with the pointer's address
	assign wr_req = '{we: write, addr: wr_addr, data: wr_data};

	// Full also counts the input buffer
	assign push_flags = '{
		full:     ram_full & last,
		ram_full: ram_full,
		af:       af,
		part_wd:  part_wd,
		error:    push_err
	};

	// --------------------
	// Storage and pop domain
	word_ram u_ram (
		.clk_push (clk_push), .wr_req  (wr_req),
		.rd_addr  (rd_addr),  .rd_data (data_out)
	);

	pop_ptr_flags u_rptr (
		.clk_pop   (clk_pop),   .rst_n   (rst_n),
		.pop_req_n (pop_req_n), .wr_gray (wr_gray),
		.rd_gray   (rd_gray),   .rd_addr (rd_addr),
		.flags     (pop_flags)
	);

endmodule

// ==== compile.f ====
asym_fifo_pkg.sv
subword_counter.sv
pack_ctl_fsm.sv
word_packer.sv
push_ptr_flags.sv
pop_ptr_flags.sv
word_ram.sv
asym_fifo_top.sv
asym_fifo_props.sv
tb_clocks.sv
asym_fifo_tb.sv

// ==== pack_ctl_fsm.sv ====
`timescale 1ns/1ps

module pack_ctl_fsm (
	input  logic clk_push,
	input  logic rst_n,
	input  logic push_req_n,
	input  logic flush_n,
	input  logic ram_full,
	input  logic last,       // Buffer holds RATIO-1 subwords
	output logic accept,     // Subword taken this cycle
	output logic write,      // Word goes to the RAM this edge
	output logic advance,
	output logic clear,
	output logic part_wd,
	output logic error       // Sticky overrun
);

	typedef enum logic {
		BUF_EMPTY,
		BUF_PART
	} state_t;

	state_t state, state_nxt;
	logic   push_full;
	logic   full_write;      // Fourth subword completes a word
	logic   flush_write;     // Flush pushes out a partial word
	logic   err_q;

	// --------------------
	// Push and flush decode
	assign push_full   = ram_full & last;
	assign accept      = ~push_req_n & ~push_full;
	assign full_write  = accept & last;  // ram_full is low here by construction
	assign flush_write = ~flush_n & (part_wd | accept) & ~ram_full;
	assign write       = full_write | flush_write;

	// Counter runs on accepts and restarts after a flush write
	assign advance = accept;
	assign clear   = flush_write;

	assign part_wd = (state == BUF_PART);
	assign error   = err_q;

	always_comb
	begin
		state_nxt = state;
		if (write)
			state_nxt = BUF_EMPTY;     // Word left, buffer drained
		else if (accept)
			state_nxt = BUF_PART;
	end

	always_ff @(posedge clk_push or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= BUF_EMPTY;
			err_q <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			// Dropped push sets the error until reset
			if (~push_req_n & push_full)
				err_q <= 1'b1;
		end
	end

endmodule

// ==== pop_ptr_flags.sv ====
`timescale 1ns/1ps

module pop_ptr_flags (
	input  logic                      clk_pop,
	input  logic                      rst_n,
	input  logic                      pop_req_n,
	input  asym_fifo_pkg::ptr_t       wr_gray,   // From the push domain
	output asym_fifo_pkg::ptr_t       rd_gray,
	output asym_fifo_pkg::addr_t      rd_addr,
	output asym_fifo_pkg::pop_flags_t flags
);

	asym_fifo_pkg::ptr_t rd_bin, rd_bin_nxt;
	asym_fifo_pkg::ptr_t wr_gray_s1, wr_gray_s2;
	asym_fifo_pkg::ptr_t wr_bin_s;
	asym_fifo_pkg::ptr_t fill;
	logic                empty;
	logic                pop;
	logic                err_q;

	assign pop        = ~pop_req_n & ~empty;  // Pop on empty is ignored
	assign rd_bin_nxt = pop ? asym_fifo_pkg::ptr_t'(rd_bin + 1'b1) : rd_bin;
	assign rd_addr    = rd_bin[asym_fifo_pkg::ADDR_W-1:0];  // Head of the FIFO

	// --------------------
	// Read pointer, sync stages and underrun
	always_ff @(posedge clk_pop or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_bin     <= '0;
			rd_gray    <= '0;
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
			err_q      <= 1'b0;
		end
		else
		begin
			rd_bin     <= rd_bin_nxt;
			rd_gray    <= asym_fifo_pkg::bin2gray(rd_bin_nxt);
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
			if (~pop_req_n & empty)
				err_q <= 1'b1;           // Sticky until reset
		end
	end

	// Stored words as seen from clk_pop
	assign wr_bin_s = asym_fifo_pkg::gray2bin(wr_gray_s2);
	assign fill     = asym_fifo_pkg::ptr_t'(wr_bin_s - rd_bin);
	assign empty    = (fill == '0);

	assign flags = '{
		empty: empty,
		ae:    (fill <= asym_fifo_pkg::AE_FILL),
		error: err_q
	};

endmodule

// ==== push_ptr_flags.sv ====
`timescale 1ns/1ps

module push_ptr_flags (
	input  logic                 clk_push,
	input  logic                 rst_n,
	input  logic                 write,
	input  asym_fifo_pkg::ptr_t  rd_gray,   // From the pop domain
	output asym_fifo_pkg::ptr_t  wr_gray,
	output asym_fifo_pkg::addr_t wr_addr,
	output logic                 ram_full,
	output logic                 af
);

	asym_fifo_pkg::ptr_t wr_bin, wr_bin_nxt;
	asym_fifo_pkg::ptr_t rd_gray_s1, rd_gray_s2;   // Two flop synchronizer
	asym_fifo_pkg::ptr_t rd_bin_s;
	asym_fifo_pkg::ptr_t fill;

	assign wr_bin_nxt = write ? asym_fifo_pkg::ptr_t'(wr_bin + 1'b1) : wr_bin;
	assign wr_addr    = wr_bin[asym_fifo_pkg::ADDR_W-1:0];

	// --------------------
	// Write pointer, binary and Gray
	always_ff @(posedge clk_push or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_bin  <= '0;
			wr_gray <= '0;
		end
		else
		begin
			wr_bin  <= wr_bin_nxt;
			wr_gray <= asym_fifo_pkg::bin2gray(wr_bin_nxt);  // Only one bit flips
		end
	end

	// Read pointer into clk_push
	always_ff @(posedge clk_push or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
		end
		else
		begin
			rd_gray_s1 <= rd_gray;
			rd_gray_s2 <= rd_gray_s1;
		end
	end

	// --------------------
	// Fill level, pessimistic since the read side lags
	assign rd_bin_s = asym_fifo_pkg::gray2bin(rd_gray_s2);
	assign fill     = asym_fifo_pkg::ptr_t'(wr_bin - rd_bin_s);
	assign ram_full = (fill == asym_fifo_pkg::FULL_LVL);
	assign af       = (fill >= asym_fifo_pkg::AF_FILL);

endmodule

// ==== run.sh ====
#!/bin/bash
verilator --binary --timing --assert --top-module asym_fifo_tb -f compile.f -o sim_fifo \
	|| { echo "Build failed"; exit 1; }
out="$(./obj_dir/sim_fifo)"
echo "$out"
echo "$out" | grep -qx ">>> PASS" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== subword_counter.sv ====
`timescale 1ns/1ps

module subword_counter (
	input  logic                clk_push,
	input  logic                rst_n,
	input  logic                advance,   // One subword accepted
	input  logic                clear,     // Flush wrote the buffer out
	output asym_fifo_pkg::cnt_t count,     // Subwords held in the buffer
	output logic                last       // Buffer holds RATIO-1 subwords
);

	// Next subword lands in the final slot
	assign last = (count == asym_fifo_pkg::LAST_CNT);

	always_ff @(posedge clk_push or negedge rst_n)
	begin
		if (!rst_n)
		begin
			count <= '0;
		end
		else if (clear)
		begin
			count <= '0;                       // Clear wins over advance
		end
		else if (advance)
		begin
			// Wrap explicitly so RATIO need not be a power of two
			if (last)
				count <= '0;
			else
				count <= asym_fifo_pkg::cnt_t'(count + 1'b1);
		end
	end

endmodule

// ==== tb_clocks.sv ====
`timescale 1ns/1ps

module tb_clocks (
	output logic clk_push,
	output logic clk_pop,
	output logic rst_n
);

	initial
	begin
		clk_push = 1'b0;
		forever #4 clk_push = ~clk_push;   // 8 ns period
	end

	initial
	begin
		clk_pop = 1'b0;
		forever #6 clk_pop = ~clk_pop;     // 12 ns period, unrelated phase
	end

	// Reset held for 16 push clocks, released on a falling edge
	initial
	begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk_push);
		@(negedge clk_push);
		rst_n = 1'b1;
	end

endmodule

// ==== word_packer.sv ====
`timescale 1ns/1ps

module word_packer (
	input  logic                     clk_push,
	input  logic                     rst_n,
	input  asym_fifo_pkg::in_word_t  data_in,
	input  asym_fifo_pkg::cnt_t      count,    // Slot for the next subword
	input  logic                     accept,
	input  logic                     write,
	output asym_fifo_pkg::out_word_t wr_data
);

	// Word viewed as subword slots, slot RATIO-1 is the MSB
	logic [asym_fifo_pkg::RATIO-1:0][asym_fifo_pkg::IN_W-1:0] hold;
	logic [asym_fifo_pkg::RATIO-1:0][asym_fifo_pkg::IN_W-1:0] slots;
	asym_fifo_pkg::cnt_t slot_idx;

	// First subword goes to the top slot
	assign slot_idx = asym_fifo_pkg::cnt_t'(asym_fifo_pkg::LAST_CNT - count);

	// --------------------
	// Held subwords
	// Unfilled slots stay zero, which gives the flush its zero fill
	always_ff @(posedge clk_push or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hold <= '0;
		end
		else if (write)
		begin
			hold <= '0;                  // Buffer drained into the RAM
		end
		else if (accept)
		begin
			hold[slot_idx] <= data_in;
		end
	end

	// --------------------
	// Word to the RAM
	always_comb
	begin
		slots = hold;
		if (accept)
			slots[slot_idx] = data_in;   // Current subword joins the word
	end

	assign wr_data = slots;

endmodule

// ==== word_ram.sv ====
`timescale 1ns/1ps

module word_ram (
	input  logic                     clk_push,
	input  asym_fifo_pkg::wr_req_t   wr_req,    // Write from the push side
	input  asym_fifo_pkg::addr_t     rd_addr,
	output asym_fifo_pkg::out_word_t rd_data
);

	asym_fifo_pkg::out_word_t mem [asym_fifo_pkg::DEPTH];

	// Write port in the push domain
	always_ff @(posedge clk_push)
	begin
		if (wr_req.we)
			mem[wr_req.addr] <= wr_req.data;
	end

	// Read port is asynchronous, so the head shows without a pop
	assign rd_data = mem[rd_addr];

endmodule
